// File: rtl/spi_proto_pkg.sv
// SPI register access protocol
// frame widths, opcode encoding and slave FSM states

package spi_proto_pkg;

    //----------------------------------------------------------------------
    // frame layout
    //----------------------------------------------------------------------
    localparam int SPI_ADDR_BITS = 7;   // address field of the command byte
    localparam int SPI_CMD_BITS  = 8;   // opcode bit + address

    // carried in the command byte MSB
    typedef enum logic {
        SPI_OP_WRITE = 1'b0,
        SPI_OP_READ  = 1'b1
    } spi_op_t;

    //----------------------------------------------------------------------
    // slave FSM
    //----------------------------------------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,     // waiting for cs
        ST_CMD  = 2'd1,     // collecting command byte
        ST_DATA = 2'd2,     // 16 data bits
        ST_DONE = 2'd3      // frame complete, wait for cs release
    } spi_state_t;

endpackage

// File: rtl/reg_map_pkg.sv
// User register map
// widths, addresses and constants of the host-visible registers

package reg_map_pkg;

    //----------------------------------------------------------------------
    // widths and types
    //----------------------------------------------------------------------
    localparam int REG_DW = 16;         // also the SPI data field length
    localparam int REG_AW = 7;

    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [REG_DW-1:0] reg_data_t;

    //----------------------------------------------------------------------
    // address map
    //----------------------------------------------------------------------
    localparam reg_addr_t REG_FW_TYPE   = 7'h00;  // read-only
    localparam reg_addr_t REG_PHY_RST   = 7'h01;
    localparam reg_addr_t REG_MDC       = 7'h02;
    localparam reg_addr_t REG_MDIO_DATA = 7'h03;
    localparam reg_addr_t REG_MDIO_DIR  = 7'h04;
    localparam reg_addr_t REG_MDIO_IN   = 7'h05;  // read-only, pin readback
    localparam reg_addr_t REG_TEST_BASE = 7'h10;

    // scratch words at 0x10..0x17
    localparam int TEST_COUNT    = 8;
    localparam int TEST_IDX_BITS = $clog2(TEST_COUNT);

    localparam int PHY_COUNT = 4;       // one reset bit per PHY

    localparam reg_data_t FW_TYPE_VALUE = 16'h0A51;

endpackage

// File: rtl/spi_edge_if.sv
// SPI pin events
// sampled sck edges, chip select level and data bit in the reg_clk domain

interface spi_edge_if;

    logic sck_rise;     // one-cycle pulse
    logic sck_fall;     // one-cycle pulse
    logic cs_active;    // high while cs_n is low
    logic mosi_bit;

    modport src (
        output sck_rise, sck_fall, cs_active, mosi_bit
    );

    modport dst (
        input  sck_rise, sck_fall, cs_active, mosi_bit
    );

endinterface

// File: rtl/reg_bus_if.sv
// Register bus
// single-cycle write strobe and combinational read data

interface reg_bus_if;

    import reg_map_pkg::*;

    reg_addr_t addr;        // stable from end of command to end of frame
    logic      wr_en;       // one-cycle pulse
    reg_data_t wr_data;
    reg_data_t rd_data;     // decode of addr

    modport master (
        output addr, wr_en, wr_data,
        input  rd_data
    );

    modport slave (
        input  addr, wr_en, wr_data,
        output rd_data
    );

endinterface

// File: rtl/spi_pin_sync.sv
// SPI pin synchroniser
// brings sck, cs_n and mosi into reg_clk and emits sck edge pulses

module spi_pin_sync (
    input  logic    reg_clk,
    input  logic    rst_i,
    input  logic    spi_sck_i,
    input  logic    spi_cs_n_i,
    input  logic    spi_mosi_i,
    spi_edge_if.src edge_o
);

    logic [1:0] sck_sync;
    logic [1:0] cs_n_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;   // last synchronised sck level

    always_ff @(posedge reg_clk) begin
        if (rst_i) begin
            sck_sync         <= 2'b00;
            cs_n_sync        <= 2'b11;  // deselected
            mosi_sync        <= 2'b00;
            sck_prev         <= 1'b0;
            edge_o.sck_rise  <= 1'b0;
            edge_o.sck_fall  <= 1'b0;
            edge_o.cs_active <= 1'b0;
            edge_o.mosi_bit  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck_i};
            cs_n_sync <= {cs_n_sync[0], spi_cs_n_i};
            mosi_sync <= {mosi_sync[0], spi_mosi_i};
            sck_prev  <= sck_sync[1];

            // third stage keeps all four events aligned
            edge_o.sck_rise  <= sck_sync[1] & ~sck_prev;
            edge_o.sck_fall  <= ~sck_sync[1] & sck_prev;
            edge_o.cs_active <= ~cs_n_sync[1];
            edge_o.mosi_bit  <= mosi_sync[1];
        end
    end

    a_edge_excl: assert property (@(posedge reg_clk) disable iff (rst_i)
        !(edge_o.sck_rise && edge_o.sck_fall));

endmodule

// File: rtl/spi_reg_slave.sv
// SPI register slave
// decodes command byte, issues register writes and shifts read data out

module spi_reg_slave (
    input  logic        reg_clk,
    input  logic        rst_i,
    spi_edge_if.dst     edge_i,
    reg_bus_if.master   bus_o,
    output logic        spi_miso_o
);

    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    spi_state_t                state;
    logic [4:0]                bit_cnt;     // sck rising edges in this frame
    spi_op_t                   op_q;
    reg_addr_t                 addr_q;
    logic                      wr_en_q;
    logic [SPI_ADDR_BITS-1:0]  cmd_sr;      // first 7 command bits
    logic [SPI_CMD_BITS-1:0]   cmd_word;    // command incl. current bit
    reg_data_t                 rx_sr;
    reg_data_t                 tx_sr;
    logic                      cmd_last;
    logic                      frame_last;

    assign cmd_word   = {cmd_sr, edge_i.mosi_bit};
    assign cmd_last   = edge_i.sck_rise && (bit_cnt == 5'(SPI_CMD_BITS - 1));
    assign frame_last = edge_i.sck_rise && (bit_cnt == 5'(SPI_CMD_BITS + REG_DW - 1));

    //----------------------------------------------------------------------
    // frame FSM
    //----------------------------------------------------------------------
    always_ff @(posedge reg_clk) begin
        if (rst_i) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            op_q    <= SPI_OP_WRITE;
            addr_q  <= '0;
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            if (!edge_i.cs_active) begin
                state <= ST_IDLE;               // abort or normal end
            end else begin
                case (state)
                    ST_IDLE: begin
                        state   <= ST_CMD;
                        bit_cnt <= '0;
                    end
                    ST_CMD: begin
                        if (edge_i.sck_rise) begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                        if (cmd_last) begin
                            op_q   <= spi_op_t'(cmd_word[SPI_CMD_BITS-1]);
                            addr_q <= cmd_word[SPI_ADDR_BITS-1:0];
                            state  <= ST_DATA;
                        end
                    end
                    ST_DATA: begin
                        if (edge_i.sck_rise) begin
                            bit_cnt <= bit_cnt + 5'd1;
                        end
                        if (frame_last) begin
                            state   <= ST_DONE;
                            wr_en_q <= (op_q == SPI_OP_WRITE);  // fires in ST_DONE
                        end
                    end
                    ST_DONE: state <= ST_DONE;  // hold until cs released
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    //----------------------------------------------------------------------
    // shift registers
    //----------------------------------------------------------------------
    always_ff @(posedge reg_clk) begin
        if (state == ST_CMD && edge_i.sck_rise) begin
            cmd_sr <= cmd_word[SPI_ADDR_BITS-1:0];
        end
        if (state == ST_DATA && edge_i.sck_rise) begin
            rx_sr <= {rx_sr[REG_DW-2:0], edge_i.mosi_bit};
        end

        if (state == ST_CMD && cmd_last) begin
            tx_sr <= bus_o.rd_data;             // MSB on miso from here
        end else if (state == ST_DATA && edge_i.sck_fall
                     && bit_cnt != 5'(SPI_CMD_BITS)) begin
            tx_sr <= {tx_sr[REG_DW-2:0], 1'b0}; // MSB held until host samples it
        end
    end

    // address is live during the command byte so rd_data is ready at bit 8
    assign bus_o.addr    = (state == ST_CMD) ? cmd_word[SPI_ADDR_BITS-1:0] : addr_q;
    assign bus_o.wr_en   = wr_en_q;
    assign bus_o.wr_data = rx_sr;

    assign spi_miso_o = edge_i.cs_active && (state == ST_DATA || state == ST_DONE)
                        && tx_sr[REG_DW-1];

    a_wr_single: assert property (@(posedge reg_clk) disable iff (rst_i)
        bus_o.wr_en |=> !bus_o.wr_en);

    a_wr_opcode: assert property (@(posedge reg_clk) disable iff (rst_i)
        bus_o.wr_en |-> op_q == SPI_OP_WRITE && state == ST_DONE);

endmodule

// File: rtl/reg_file.sv
// User register file
// PHY reset and bit-banged MDIO registers plus scratch words

module reg_file (
    input  logic                            reg_clk,
    input  logic                            rst_i,
    reg_bus_if.slave                        bus_i,
    input  logic                            mdio_i,
    output logic [reg_map_pkg::PHY_COUNT-1:0] phy_rst_o,
    output logic                            mdc_o,
    output logic                            mdio_o,
    output logic                            mdio_oe_o
);

    import reg_map_pkg::*;

    logic [PHY_COUNT-1:0]     phy_rst_q;
    logic                     mdc_q;
    logic                     mdio_data_q;
    logic                     mdio_dir_q;
    reg_data_t                test_mem [TEST_COUNT];
    reg_addr_t                test_off;
    logic                     test_hit;
    logic [TEST_IDX_BITS-1:0] test_idx;
    logic [1:0]               mdio_sync;    // async pin

    assign test_off = bus_i.addr - REG_TEST_BASE;   // wraps high below base
    assign test_hit = (test_off < TEST_COUNT);
    assign test_idx = test_off[TEST_IDX_BITS-1:0];

    //----------------------------------------------------------------------
    // write decode
    //----------------------------------------------------------------------
    always_ff @(posedge reg_clk) begin
        if (rst_i) begin
            phy_rst_q   <= '0;
            mdc_q       <= 1'b0;
            mdio_data_q <= 1'b0;
            mdio_dir_q  <= 1'b0;
            test_mem    <= '{default: '0};
        end else if (bus_i.wr_en) begin
            case (bus_i.addr)
                REG_PHY_RST:   phy_rst_q   <= bus_i.wr_data[PHY_COUNT-1:0];
                REG_MDC:       mdc_q       <= bus_i.wr_data[0];
                REG_MDIO_DATA: mdio_data_q <= bus_i.wr_data[0];
                REG_MDIO_DIR:  mdio_dir_q  <= bus_i.wr_data[0];
                default: begin
                    if (test_hit) begin
                        test_mem[test_idx] <= bus_i.wr_data;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge reg_clk) begin
        mdio_sync <= {mdio_sync[0], mdio_i};
    end

    //----------------------------------------------------------------------
    // read mux
    //----------------------------------------------------------------------
    always_comb begin
        bus_i.rd_data = '0;                 // unmapped reads as zero
        case (bus_i.addr)
            REG_FW_TYPE:   bus_i.rd_data = FW_TYPE_VALUE;
            REG_PHY_RST:   bus_i.rd_data = reg_data_t'(phy_rst_q);
            REG_MDC:       bus_i.rd_data = reg_data_t'(mdc_q);
            REG_MDIO_DATA: bus_i.rd_data = reg_data_t'(mdio_data_q);
            REG_MDIO_DIR:  bus_i.rd_data = reg_data_t'(mdio_dir_q);
            REG_MDIO_IN:   bus_i.rd_data = reg_data_t'(mdio_sync[1]);
            default: begin
                if (test_hit) begin
                    bus_i.rd_data = test_mem[test_idx];
                end
            end
        endcase
    end

    assign phy_rst_o = phy_rst_q;
    assign mdc_o     = mdc_q;
    assign mdio_o    = mdio_data_q;
    assign mdio_oe_o = mdio_dir_q;      // drives the board tristate

    a_phy_rst_wr: assert property (@(posedge reg_clk) disable iff (rst_i)
        (bus_i.wr_en && bus_i.addr == REG_PHY_RST)
        |=> phy_rst_o == $past(bus_i.wr_data[PHY_COUNT-1:0]));

endmodule

// File: rtl/spi_ctrl_top.sv
// SPI register access top level
// pin synchroniser, SPI slave and register file on one clock

module spi_ctrl_top (
    input  logic                              reg_clk,
    input  logic                              rst_i,
    input  logic                              spi_sck_i,
    input  logic                              spi_cs_n_i,
    input  logic                              spi_mosi_i,
    output logic                              spi_miso_o,
    input  logic                              mdio_i,
    output logic [reg_map_pkg::PHY_COUNT-1:0] phy_rst_o,
    output logic                              mdc_o,
    output logic                              mdio_o,
    output logic                              mdio_oe_o
);

    spi_edge_if spi_edge ();
    reg_bus_if  reg_bus ();

    spi_pin_sync spi_pin_sync_inst (
        .reg_clk    (reg_clk),
        .rst_i      (rst_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .edge_o     (spi_edge.src)
    );

    spi_reg_slave spi_reg_slave_inst (
        .reg_clk    (reg_clk),
        .rst_i      (rst_i),
        .edge_i     (spi_edge.dst),
        .bus_o      (reg_bus.master),
        .spi_miso_o (spi_miso_o)
    );

    reg_file reg_file_inst (
        .reg_clk    (reg_clk),
        .rst_i      (rst_i),
        .bus_i      (reg_bus.slave),
        .mdio_i     (mdio_i),
        .phy_rst_o  (phy_rst_o),
        .mdc_o      (mdc_o),
        .mdio_o     (mdio_o),
        .mdio_oe_o  (mdio_oe_o)
    );

endmodule

// File: testbench/tb_spi_ctrl.sv
// Testbench for the SPI register access top level
// SPI master tasks, shadow register model and result checker

module tb_spi_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    import spi_proto_pkg::*;
    import reg_map_pkg::*;

    localparam int HALF_SCK       = 4;      // reg_clk cycles per sck phase
    localparam int CS_GAP         = 8;
    localparam int FRAME_BITS     = SPI_CMD_BITS + REG_DW;
    localparam int TIMEOUT_CYCLES = 20000;  // ~40 frames plus gaps, with margin

    logic                 reg_clk;
    logic                 rst_i;
    logic                 spi_sck_i;
    logic                 spi_cs_n_i;
    logic                 spi_mosi_i;
    logic                 spi_miso_o;
    logic                 mdio_i;
    logic [PHY_COUNT-1:0] phy_rst_o;
    logic                 mdc_o;
    logic                 mdio_o;
    logic                 mdio_oe_o;

    logic [15:0] shadow [128] = '{default: '0};    // last value written per address
    logic [15:0] exp_q [$];
    logic [15:0] act_q [$];
    string       name_q [$];
    int          check_cnt = 0;
    int          error_cnt = 0;
    int          cycle_cnt = 0;

    spi_ctrl_top spi_ctrl_top_inst (
        .reg_clk    (reg_clk),
        .rst_i      (rst_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_n_i (spi_cs_n_i),
        .spi_mosi_i (spi_mosi_i),
        .spi_miso_o (spi_miso_o),
        .mdio_i     (mdio_i),
        .phy_rst_o  (phy_rst_o),
        .mdc_o      (mdc_o),
        .mdio_o     (mdio_o),
        .mdio_oe_o  (mdio_oe_o)
    );

    initial begin
        reg_clk = 1'b0;
        forever #2 reg_clk = ~reg_clk;
    end

    //----------------------------------------------------------------------
    // reference model
    //----------------------------------------------------------------------
    function automatic logic [15:0] ref_read(input logic [6:0] addr);
        logic [15:0] val;
        val = 16'h0000;                         // unmapped
        if (addr == REG_FW_TYPE) begin
            val = FW_TYPE_VALUE;
        end else if (addr == REG_PHY_RST) begin
            val = {12'h000, shadow[addr][3:0]};
        end else if (addr == REG_MDC || addr == REG_MDIO_DATA || addr == REG_MDIO_DIR) begin
            val = {15'h0000, shadow[addr][0]};
        end else if (addr == REG_MDIO_IN) begin
            val = {15'h0000, mdio_i};           // live pin level
        end else if (addr >= REG_TEST_BASE && addr < REG_TEST_BASE + TEST_COUNT) begin
            val = shadow[addr];
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_cnt++;
        if (actual !== expected) begin
            error_cnt++;
            $display("Mismatch %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
        end
    endtask

    task automatic post_result(input string name, input logic [15:0] exp_v,
                               input logic [15:0] act_v);
        name_q.push_back(name);
        exp_q.push_back(exp_v);
        act_q.push_back(act_v);
    endtask

    // compare process drains the result queues
    initial begin
        forever begin
            @(posedge reg_clk);
            while (act_q.size() > 0) begin
                check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
            end
        end
    end

    //----------------------------------------------------------------------
    // SPI master, mode 0
    //----------------------------------------------------------------------
    task automatic spi_transfer(input logic rd, input logic [6:0] addr,
                                input logic [15:0] wdata, input int nbits,
                                output logic [15:0] rdata);
        logic [23:0] frame;
        int          i;
        frame      = {rd, addr, wdata};
        rdata      = 16'h0000;
        spi_cs_n_i = 1'b0;
        for (i = 0; i < nbits; i++) begin
            spi_mosi_i = frame[23-i];           // change while sck low
            repeat (HALF_SCK) @(negedge reg_clk);
            if (i >= SPI_CMD_BITS) begin
                rdata = {rdata[14:0], spi_miso_o};
            end
            spi_sck_i = 1'b1;
            repeat (HALF_SCK) @(negedge reg_clk);
            spi_sck_i = 1'b0;
        end
        repeat (HALF_SCK) @(negedge reg_clk);
        spi_cs_n_i = 1'b1;
        spi_mosi_i = 1'b0;
        repeat (CS_GAP) @(negedge reg_clk);
    endtask

    task automatic spi_write(input logic [6:0] addr, input logic [15:0] wdata);
        logic [15:0] unused_rd;
        spi_transfer(SPI_OP_WRITE, addr, wdata, FRAME_BITS, unused_rd);
        shadow[addr] = wdata;
    endtask

    task automatic spi_read(input logic [6:0] addr, output logic [15:0] rdata);
        spi_transfer(SPI_OP_READ, addr, 16'h0000, FRAME_BITS, rdata);
    endtask

    task automatic read_check(input string name, input logic [6:0] addr);
        logic [15:0] rdata;
        spi_read(addr, rdata);
        post_result(name, ref_read(addr), rdata);
    endtask

    //----------------------------------------------------------------------
    // stimulus
    //----------------------------------------------------------------------
    initial begin
        logic [15:0] unused_rd;
        int          i;
        void'($urandom(32'hd879));
        rst_i      = 1'b1;
        spi_sck_i  = 1'b0;
        spi_cs_n_i = 1'b1;
        spi_mosi_i = 1'b0;
        mdio_i     = 1'b0;
        repeat (10) @(negedge reg_clk);
        rst_i = 1'b0;
        repeat (4) @(negedge reg_clk);

        for (i = 0; i <= 4; i++) begin          // fw type and reset values
            read_check($sformatf("reset read 0x%02h", i), 7'(i));
        end
        for (i = 0; i < TEST_COUNT; i++) begin
            read_check($sformatf("reset test word %0d", i), REG_TEST_BASE + 7'(i));
        end

        for (i = 0; i < TEST_COUNT; i++) begin
            spi_write(REG_TEST_BASE + 7'(i), 16'($urandom()));
        end
        for (i = 0; i < TEST_COUNT; i++) begin
            read_check($sformatf("test word %0d", i), REG_TEST_BASE + 7'(i));
        end

        spi_write(REG_PHY_RST, 16'($urandom()));
        post_result("phy_rst_o pins", {12'h000, shadow[REG_PHY_RST][3:0]}, 16'(phy_rst_o));
        read_check("phy reset readback", REG_PHY_RST);

        // each pin checked right after its own write, others still at 0
        spi_write(REG_MDC, 16'h0001);
        post_result("mdc_o pin", {15'h0000, shadow[REG_MDC][0]}, 16'(mdc_o));
        spi_write(REG_MDIO_DATA, 16'($urandom()) | 16'h0001);
        post_result("mdio_o pin", {15'h0000, shadow[REG_MDIO_DATA][0]}, 16'(mdio_o));
        spi_write(REG_MDIO_DIR, 16'hfff1);
        post_result("mdio_oe_o pin", {15'h0000, shadow[REG_MDIO_DIR][0]}, 16'(mdio_oe_o));
        read_check("mdio dir readback", REG_MDIO_DIR);
        mdio_i = 1'b1;
        read_check("mdio in high", REG_MDIO_IN);
        mdio_i = 1'b0;
        read_check("mdio in low", REG_MDIO_IN);

        // cs released after 12 bits, word 2 must keep its value
        spi_transfer(SPI_OP_WRITE, REG_TEST_BASE + 7'd2, ~shadow[REG_TEST_BASE + 7'd2],
                     12, unused_rd);
        read_check("aborted write", REG_TEST_BASE + 7'd2);
        spi_write(REG_TEST_BASE + 7'd2, 16'h5aa5);
        read_check("write after abort", REG_TEST_BASE + 7'd2);

        read_check("unmapped 0x30", 7'h30);
        spi_write(REG_FW_TYPE, ~FW_TYPE_VALUE);
        read_check("fw type after write", REG_FW_TYPE);

        wait (act_q.size() == 0);
        @(negedge reg_clk);
        $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge reg_clk);
            cycle_cnt++;
        end
        $display("run timed out after %0d cycles, errors so far: %0d", cycle_cnt, error_cnt);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: flist.f
rtl/spi_proto_pkg.sv
rtl/reg_map_pkg.sv
rtl/spi_edge_if.sv
rtl/reg_bus_if.sv
rtl/spi_pin_sync.sv
rtl/spi_reg_slave.sv
rtl/reg_file.sv
rtl/spi_ctrl_top.sv
testbench/tb_spi_ctrl.sv

// File: Bender.yml
package:
  name: spi_ctrl

sources:
  - files:
      - rtl/spi_proto_pkg.sv
      - rtl/reg_map_pkg.sv
      - rtl/spi_edge_if.sv
      - rtl/reg_bus_if.sv
      - rtl/spi_pin_sync.sv
      - rtl/spi_reg_slave.sv
      - rtl/reg_file.sv
      - rtl/spi_ctrl_top.sv

  - target: test
    files:
      - testbench/tb_spi_ctrl.sv
